//--- hw/mem_pkg.sv
package mem_pkg;

  // ============================================================
  // Array geometry and bus widths
  // ============================================================
  localparam int MEM_WORDS   = 256;
  localparam int DATA_W      = 32;
  localparam int WORD_ADDR_W = 8;
  localparam int AXI_ADDR_W  = 12;
  localparam int STRB_W      = DATA_W / 8;
  localparam int ADDR_LSB    = $clog2(STRB_W);   // Byte offset bits within a word

  typedef logic [DATA_W-1:0]      data_t;
  typedef logic [WORD_ADDR_W-1:0] word_addr_t;
  typedef logic [AXI_ADDR_W-1:0]  axi_addr_t;
  typedef logic [STRB_W-1:0]      strb_t;

  // ============================================================
  // Memory request and port control
  // ============================================================
  typedef struct packed {
    logic       valid;
    logic       write;
    word_addr_t addr;
    strb_t      strb;    // Byte enables, zero for reads
    data_t      wdata;
  } mem_req_t;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,              // Request presented, waiting for grant
    RESP                 // Response held until master ready
  } port_state_e;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- hw/clock_gate.sv
`timescale 1ns/1ps

module clock_gate (
  input  logic clk_i,
  input  logic en_i,
  input  logic bypass_i,
  output logic gated_clk_o
);

  logic en_latch;

  // Enable only changes while clock is low, so no glitch on the gated edge
  always_latch
  begin
    if (!clk_i)
    begin
      en_latch <= en_i;
    end
  end

  assign gated_clk_o = clk_i & (en_latch | bypass_i);   // Bypass keeps clock running

endmodule

//--- hw/mem_2rw_sync_synth.sv
`timescale 1ns/1ps

module mem_2rw_sync_synth
  import mem_pkg::*;
(
  input  logic     clk_i,
  input  mem_req_t a_req_i,
  input  mem_req_t b_req_i,
  output data_t    a_data_o,
  output data_t    b_data_o
);

  data_t mem [MEM_WORDS];

  // ============================================================
  // Side A
  // ============================================================
  always_ff @(posedge clk_i)
  begin
    if (a_req_i.valid && a_req_i.write)
    begin
      for (int i = 0; i < STRB_W; i++)
      begin
        if (a_req_i.strb[i])
          mem[a_req_i.addr][8*i +: 8] <= a_req_i.wdata[8*i +: 8];
      end
    end
    if (a_req_i.valid && !a_req_i.write)
      a_data_o <= mem[a_req_i.addr];   // Held until next read on this side
  end

  // ============================================================
  // Side B
  // ============================================================
  always_ff @(posedge clk_i)
  begin
    if (b_req_i.valid && b_req_i.write)
    begin
      for (int i = 0; i < STRB_W; i++)
      begin
        if (b_req_i.strb[i])
          mem[b_req_i.addr][8*i +: 8] <= b_req_i.wdata[8*i +: 8];
      end
    end
    if (b_req_i.valid && !b_req_i.write)
      b_data_o <= mem[b_req_i.addr];
  end

endmodule

//--- hw/mem_2rw_sync.sv
`timescale 1ns/1ps

module mem_2rw_sync
  import mem_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     gate_en_i,
  input  mem_req_t a_req_i,
  input  mem_req_t b_req_i,
  output data_t    a_data_o,
  output data_t    b_data_o
);

  logic  array_clk;
  logic  a_rd_seen_q;
  logic  b_rd_seen_q;
  data_t a_array_data;
  data_t b_array_data;

  // Array clock only runs while a granted request is present
  clock_gate icg (
    .clk_i       (clk_i),
    .en_i        (a_req_i.valid | b_req_i.valid),
    .bypass_i    (~gate_en_i),
    .gated_clk_o (array_clk)
  );

  mem_2rw_sync_synth synth (
    .clk_i    (array_clk),
    .a_req_i  (a_req_i),
    .b_req_i  (b_req_i),
    .a_data_o (a_array_data),
    .b_data_o (b_array_data)
  );

  // ============================================================
  // Read data clear after reset
  // ============================================================
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      a_rd_seen_q <= 1'b0;
      b_rd_seen_q <= 1'b0;
    end
    else
    begin
      if (a_req_i.valid && !a_req_i.write)
        a_rd_seen_q <= 1'b1;
      if (b_req_i.valid && !b_req_i.write)
        b_rd_seen_q <= 1'b1;
    end
  end

  // Output reads as zero until the first read on that side
  assign a_data_o = a_rd_seen_q ? a_array_data : '0;
  assign b_data_o = b_rd_seen_q ? b_array_data : '0;

endmodule

//--- hw/mem_port_arbiter.sv
`timescale 1ns/1ps

module mem_port_arbiter
  import mem_pkg::*;
(
  input  mem_req_t a_req_i,
  input  mem_req_t b_req_i,
  output mem_req_t a_req_o,
  output mem_req_t b_req_o,
  output logic     a_grant_o,
  output logic     b_grant_o
);

  logic same_word;
  logic any_write;
  logic conflict;

  // ============================================================
  // Same-word conflict detection
  // ============================================================
  assign same_word = (a_req_i.addr == b_req_i.addr);
  assign any_write = a_req_i.write | b_req_i.write;
  assign conflict  = a_req_i.valid & b_req_i.valid & same_word & any_write;

  // A always wins, B retries next cycle with the same request
  assign a_grant_o = a_req_i.valid;
  assign b_grant_o = b_req_i.valid & ~conflict;

  always_comb
  begin
    a_req_o       = a_req_i;
    a_req_o.valid = a_grant_o;
    b_req_o       = b_req_i;
    b_req_o.valid = b_grant_o;   // Stalled request never reaches the array
  end

endmodule

//--- hw/axil_mem_port.sv
`timescale 1ns/1ps

module axil_mem_port
  import mem_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,

  input  axi_addr_t  s_awaddr_i,
  input  logic       s_awvalid_i,
  output logic       s_awready_o,
  input  data_t      s_wdata_i,
  input  strb_t      s_wstrb_i,
  input  logic       s_wvalid_i,
  output logic       s_wready_o,
  output logic [1:0] s_bresp_o,
  output logic       s_bvalid_o,
  input  logic       s_bready_i,
  input  axi_addr_t  s_araddr_i,
  input  logic       s_arvalid_i,
  output logic       s_arready_o,
  output data_t      s_rdata_o,
  output logic [1:0] s_rresp_o,
  output logic       s_rvalid_o,
  input  logic       s_rready_i,

  output mem_req_t   req_o,
  input  logic       grant_i,
  input  data_t      rdata_i
);

  port_state_e state_q;
  mem_req_t    req_q;
  logic        rd_wait_q;
  logic        bvalid_q;
  logic        rvalid_q;
  logic [1:0]  resp_q;
  data_t       rdata_q;

  logic        aw_hs;
  logic        ar_hs;
  logic        aw_oor;
  logic        ar_oor;

  // ============================================================
  // Channel handshakes
  // ============================================================
  // Write needs AW and W together, read waits while any write is pending
  assign s_awready_o = (state_q == IDLE) & s_awvalid_i & s_wvalid_i;
  assign s_wready_o  = s_awready_o;
  assign s_arready_o = (state_q == IDLE) & s_arvalid_i & ~(s_awvalid_i | s_wvalid_i);

  assign aw_hs = s_awready_o;
  assign ar_hs = s_arready_o;

  // Array covers 1 KB of the 4 KB window
  assign aw_oor = |s_awaddr_i[AXI_ADDR_W-1:ADDR_LSB+WORD_ADDR_W];
  assign ar_oor = |s_araddr_i[AXI_ADDR_W-1:ADDR_LSB+WORD_ADDR_W];

  // ============================================================
  // Port FSM
  // ============================================================
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q   <= IDLE;
      req_q     <= '0;
      rd_wait_q <= 1'b0;
      bvalid_q  <= 1'b0;
      rvalid_q  <= 1'b0;
      resp_q    <= RESP_OKAY;
      rdata_q   <= '0;
    end
    else
    begin
      case (state_q)
        IDLE:
        begin
          if (aw_hs)
          begin
            if (aw_oor)
            begin
              bvalid_q <= 1'b1;
              resp_q   <= RESP_SLVERR;
              state_q  <= RESP;
            end
            else
            begin
              req_q   <= '{valid: 1'b1, write: 1'b1,
                           addr: s_awaddr_i[ADDR_LSB +: WORD_ADDR_W],
                           strb: s_wstrb_i, wdata: s_wdata_i};
              state_q <= ACCESS;
            end
          end
          else if (ar_hs)
          begin
            if (ar_oor)
            begin
              rvalid_q <= 1'b1;
              resp_q   <= RESP_SLVERR;
              rdata_q  <= '0;
              state_q  <= RESP;
            end
            else
            begin
              req_q   <= '{valid: 1'b1, write: 1'b0,
                           addr: s_araddr_i[ADDR_LSB +: WORD_ADDR_W],
                           strb: '0, wdata: '0};
              state_q <= ACCESS;
            end
          end
        end
        ACCESS:
        begin
          if (grant_i)
          begin
            req_q.valid <= 1'b0;
            state_q     <= RESP;
            if (req_q.write)
            begin
              bvalid_q <= 1'b1;
              resp_q   <= RESP_OKAY;
            end
            else
              rd_wait_q <= 1'b1;   // Array data lands next cycle
          end
        end
        RESP:
        begin
          if (rd_wait_q)
          begin
            rd_wait_q <= 1'b0;
            rvalid_q  <= 1'b1;
            resp_q    <= RESP_OKAY;
            rdata_q   <= rdata_i;
          end
          if (bvalid_q && s_bready_i)
          begin
            bvalid_q <= 1'b0;
            state_q  <= IDLE;
          end
          if (rvalid_q && s_rready_i)
          begin
            rvalid_q <= 1'b0;
            state_q  <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign req_o = req_q;

  assign s_bvalid_o = bvalid_q;
  assign s_bresp_o  = resp_q;
  assign s_rvalid_o = rvalid_q;
  assign s_rresp_o  = resp_q;
  assign s_rdata_o  = rdata_q;

endmodule

//--- hw/dual_port_mem_top.sv
`timescale 1ns/1ps

module dual_port_mem_top
  import mem_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       gate_en_i,

  input  axi_addr_t  a_s_awaddr_i,
  input  logic       a_s_awvalid_i,
  output logic       a_s_awready_o,
  input  data_t      a_s_wdata_i,
  input  strb_t      a_s_wstrb_i,
  input  logic       a_s_wvalid_i,
  output logic       a_s_wready_o,
  output logic [1:0] a_s_bresp_o,
  output logic       a_s_bvalid_o,
  input  logic       a_s_bready_i,
  input  axi_addr_t  a_s_araddr_i,
  input  logic       a_s_arvalid_i,
  output logic       a_s_arready_o,
  output data_t      a_s_rdata_o,
  output logic [1:0] a_s_rresp_o,
  output logic       a_s_rvalid_o,
  input  logic       a_s_rready_i,

  input  axi_addr_t  b_s_awaddr_i,
  input  logic       b_s_awvalid_i,
  output logic       b_s_awready_o,
  input  data_t      b_s_wdata_i,
  input  strb_t      b_s_wstrb_i,
  input  logic       b_s_wvalid_i,
  output logic       b_s_wready_o,
  output logic [1:0] b_s_bresp_o,
  output logic       b_s_bvalid_o,
  input  logic       b_s_bready_i,
  input  axi_addr_t  b_s_araddr_i,
  input  logic       b_s_arvalid_i,
  output logic       b_s_arready_o,
  output data_t      b_s_rdata_o,
  output logic [1:0] b_s_rresp_o,
  output logic       b_s_rvalid_o,
  input  logic       b_s_rready_i
);

  mem_req_t a_port_req;
  mem_req_t b_port_req;
  mem_req_t a_ram_req;     // After arbitration
  mem_req_t b_ram_req;
  logic     a_grant;
  logic     b_grant;
  data_t    a_ram_data;
  data_t    b_ram_data;

  // ============================================================
  // AXI4-Lite ports
  // ============================================================
  axil_mem_port port_a (
    .clk_i       (clk_i),          .arst_n_i    (arst_n_i),
    .s_awaddr_i  (a_s_awaddr_i),   .s_awvalid_i (a_s_awvalid_i),
    .s_awready_o (a_s_awready_o),  .s_wdata_i   (a_s_wdata_i),
    .s_wstrb_i   (a_s_wstrb_i),    .s_wvalid_i  (a_s_wvalid_i),
    .s_wready_o  (a_s_wready_o),   .s_bresp_o   (a_s_bresp_o),
    .s_bvalid_o  (a_s_bvalid_o),   .s_bready_i  (a_s_bready_i),
    .s_araddr_i  (a_s_araddr_i),   .s_arvalid_i (a_s_arvalid_i),
    .s_arready_o (a_s_arready_o),  .s_rdata_o   (a_s_rdata_o),
    .s_rresp_o   (a_s_rresp_o),    .s_rvalid_o  (a_s_rvalid_o),
    .s_rready_i  (a_s_rready_i),
    .req_o       (a_port_req),     .grant_i     (a_grant),
    .rdata_i     (a_ram_data)
  );

  axil_mem_port port_b (
    .clk_i       (clk_i),          .arst_n_i    (arst_n_i),
    .s_awaddr_i  (b_s_awaddr_i),   .s_awvalid_i (b_s_awvalid_i),
    .s_awready_o (b_s_awready_o),  .s_wdata_i   (b_s_wdata_i),
    .s_wstrb_i   (b_s_wstrb_i),    .s_wvalid_i  (b_s_wvalid_i),
    .s_wready_o  (b_s_wready_o),   .s_bresp_o   (b_s_bresp_o),
    .s_bvalid_o  (b_s_bvalid_o),   .s_bready_i  (b_s_bready_i),
    .s_araddr_i  (b_s_araddr_i),   .s_arvalid_i (b_s_arvalid_i),
    .s_arready_o (b_s_arready_o),  .s_rdata_o   (b_s_rdata_o),
    .s_rresp_o   (b_s_rresp_o),    .s_rvalid_o  (b_s_rvalid_o),
    .s_rready_i  (b_s_rready_i),
    .req_o       (b_port_req),     .grant_i     (b_grant),
    .rdata_i     (b_ram_data)
  );

  // ============================================================
  // Arbitration and RAM
  // ============================================================
  mem_port_arbiter arb (
    .a_req_i   (a_port_req),
    .b_req_i   (b_port_req),
    .a_req_o   (a_ram_req),
    .b_req_o   (b_ram_req),
    .a_grant_o (a_grant),
    .b_grant_o (b_grant)
  );

  mem_2rw_sync ram (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .gate_en_i (gate_en_i),
    .a_req_i   (a_ram_req),
    .b_req_i   (b_ram_req),
    .a_data_o  (a_ram_data),
    .b_data_o  (b_ram_data)
  );

endmodule

//--- verification/axil_master_tasks.svh
// Bits 11:10 above the 1 KB array select unmapped space
function automatic logic [1:0] expected_resp(input axi_addr_t addr);
  return (addr[11:10] != 2'b00) ? RESP_SLVERR : RESP_OKAY;
endfunction

task automatic note_timeout(input int p, input string what);
  $display("Timeout at %0t: port %0d never raised %s", $time, p, what);
  timed_out = 1'b1;
  err_cnt++;
endtask

// Waits for B or R, keeps ready low for hold cycles, then takes the response
task automatic finish_resp(input int p, input logic is_wr, input int hold, output data_t data);
  int   n;
  logic seen;
  seen = 1'b0;
  data = '0;
  for (n = 0; n < TIMEOUT_CYC; n++)
  begin
    @(negedge clk);
    seen = is_wr ? bvalid[p] : rvalid[p];
    if (seen)
      break;
  end
  if (!seen)
  begin
    note_timeout(p, is_wr ? "bvalid" : "rvalid");
    return;
  end
  data = rdata[p];
  repeat (hold) @(negedge clk);   // Response must stay put meanwhile
  @(posedge clk);
  if (is_wr)
    bready[p] <= 1'b1;
  else
    rready[p] <= 1'b1;
  @(posedge clk);                 // Response taken on this edge
  bready[p] <= 1'b0;
  rready[p] <= 1'b0;
endtask

task automatic axil_write(input int p, input axi_addr_t addr, input data_t data,
                          input strb_t strb, input int hold);
  int    n;
  data_t unused_data;
  if (timed_out)
    return;
  @(posedge clk);
  exp_resp[p] = expected_resp(addr);
  awaddr[p]  <= addr;
  awvalid[p] <= 1'b1;
  wdata[p]   <= data;
  wstrb[p]   <= strb;
  wvalid[p]  <= 1'b1;
  for (n = 0; n < TIMEOUT_CYC; n++)
  begin
    @(negedge clk);
    if (awready[p] && wready[p])
      break;
  end
  if (n == TIMEOUT_CYC)
  begin
    note_timeout(p, "awready and wready");
    return;
  end
  @(posedge clk);                 // AW and W handshake
  awvalid[p] <= 1'b0;
  wvalid[p]  <= 1'b0;
  finish_resp(p, 1'b1, hold, unused_data);
endtask

task automatic axil_read(input int p, input axi_addr_t addr, input int hold,
                         output data_t data);
  int n;
  data = '0;
  if (timed_out)
    return;
  @(posedge clk);
  exp_resp[p] = expected_resp(addr);
  araddr[p]  <= addr;
  arvalid[p] <= 1'b1;
  for (n = 0; n < TIMEOUT_CYC; n++)
  begin
    @(negedge clk);
    if (arready[p])
      break;
  end
  if (n == TIMEOUT_CYC)
  begin
    note_timeout(p, "arready");
    return;
  end
  @(posedge clk);                 // AR handshake
  arvalid[p] <= 1'b0;
  finish_resp(p, 1'b0, hold, data);
endtask

//--- verification/dual_port_mem_tb.sv
`timescale 1ns/1ps

module dual_port_mem_tb
  import mem_pkg::*;
();

  localparam int TIMEOUT_CYC = 200;

  logic        clk = 1'b0;
  logic        arst_n;
  logic        gate_en;
  axi_addr_t   awaddr  [2];
  logic        awvalid [2];
  logic        awready [2];
  data_t       wdata   [2];
  strb_t       wstrb   [2];
  logic        wvalid  [2];
  logic        wready  [2];
  logic [1:0]  bresp   [2];
  logic        bvalid  [2];
  logic        bready  [2];
  axi_addr_t   araddr  [2];
  logic        arvalid [2];
  logic        arready [2];
  data_t       rdata   [2];
  logic [1:0]  rresp   [2];
  logic        rvalid  [2];
  logic        rready  [2];
  logic [1:0]  exp_resp [2];   // Response code the current transaction must get
  data_t       model [MEM_WORDS];
  int          err_cnt = 0;
  int          chk_cnt = 0;
  int          test_cnt = 0;
  logic        timed_out = 1'b0;

  always #4 clk = ~clk;

  dual_port_mem_top dut0 (
    .clk_i         (clk),         .arst_n_i      (arst_n),
    .gate_en_i     (gate_en),
    .a_s_awaddr_i  (awaddr[0]),   .a_s_awvalid_i (awvalid[0]),
    .a_s_awready_o (awready[0]),  .a_s_wdata_i   (wdata[0]),
    .a_s_wstrb_i   (wstrb[0]),    .a_s_wvalid_i  (wvalid[0]),
    .a_s_wready_o  (wready[0]),   .a_s_bresp_o   (bresp[0]),
    .a_s_bvalid_o  (bvalid[0]),   .a_s_bready_i  (bready[0]),
    .a_s_araddr_i  (araddr[0]),   .a_s_arvalid_i (arvalid[0]),
    .a_s_arready_o (arready[0]),  .a_s_rdata_o   (rdata[0]),
    .a_s_rresp_o   (rresp[0]),    .a_s_rvalid_o  (rvalid[0]),
    .a_s_rready_i  (rready[0]),
    .b_s_awaddr_i  (awaddr[1]),   .b_s_awvalid_i (awvalid[1]),
    .b_s_awready_o (awready[1]),  .b_s_wdata_i   (wdata[1]),
    .b_s_wstrb_i   (wstrb[1]),    .b_s_wvalid_i  (wvalid[1]),
    .b_s_wready_o  (wready[1]),   .b_s_bresp_o   (bresp[1]),
    .b_s_bvalid_o  (bvalid[1]),   .b_s_bready_i  (bready[1]),
    .b_s_araddr_i  (araddr[1]),   .b_s_arvalid_i (arvalid[1]),
    .b_s_arready_o (arready[1]),  .b_s_rdata_o   (rdata[1]),
    .b_s_rresp_o   (rresp[1]),    .b_s_rvalid_o  (rvalid[1]),
    .b_s_rready_i  (rready[1])
  );

  // ============================================================
  // Helpers and master tasks
  // ============================================================
  function automatic data_t merge(input data_t old, input data_t nw, input strb_t s);
    data_t r;
    r = old;
    for (int i = 0; i < 4; i++)
    begin
      if (s[i])
        r[8*i +: 8] = nw[8*i +: 8];
    end
    return r;
  endfunction

  function automatic axi_addr_t byte_addr(input word_addr_t w);
    return {2'b00, w, 2'b00};
  endfunction

  task automatic check_data(input string what, input data_t got, input data_t exp);
    chk_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("Fail @ %0t: %s returned %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic assert_fail(input int p, input string msg);
    err_cnt++;
    $display("Fail @ %0t: port %0d %s", $time, p, msg);
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_cnt++;
    $display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
  endtask

  `include "axil_master_tasks.svh"

  // ============================================================
  // Protocol assertions
  // ============================================================
  for (genvar p = 0; p < 2; p++)
  begin : g_axi_chk
    assert property (@(posedge clk) !arst_n |=>
                     !awready[p] && !wready[p] && !arready[p] && !bvalid[p] && !rvalid[p])
      else assert_fail(p, "has a ready or valid high after reset");
    assert property (@(posedge clk) disable iff (!arst_n)
                     bvalid[p] && !bready[p] |=> bvalid[p] && $stable(bresp[p]))
      else assert_fail(p, "dropped or changed its B response before bready");
    assert property (@(posedge clk) disable iff (!arst_n)
                     rvalid[p] && !rready[p] |=>
                     rvalid[p] && $stable(rresp[p]) && $stable(rdata[p]))
      else assert_fail(p, "dropped or changed its R response before rready");
    assert property (@(posedge clk) disable iff (!arst_n)
                     bvalid[p] |-> bresp[p] == exp_resp[p])
      else assert_fail(p, "gave the wrong bresp code");
    assert property (@(posedge clk) disable iff (!arst_n)
                     rvalid[p] |-> rresp[p] == exp_resp[p])
      else assert_fail(p, "gave the wrong rresp code");
  end

  // Port hp holds its responses while the other port keeps running
  task automatic backpressure_run(input int hp);
    logic [31:0] r;
    word_addr_t  w0;
    data_t       d;
    data_t       got;
    int          hold;
    int          other_done;
    r          = $urandom;
    w0         = r[7:0];
    hold       = 20 + int'(r[11:8]);
    d          = $urandom;
    other_done = 0;
    fork
      begin
        axil_write(hp, byte_addr(w0), d, 4'hf, hold);
        model[w0] = d;
        axil_read(hp, byte_addr(w0), hold, got);
        check_data("held read", got, model[w0]);
        chk_cnt++;
        if (other_done == 0)
          assert_fail(1 - hp, "completed nothing while the other port was held");
      end
      begin
        for (int j = 0; j < 8; j++)
        begin
          word_addr_t w;
          data_t      dd;
          data_t      gg;
          w  = w0 ^ word_addr_t'(j + 1);    // Never the held word
          dd = $urandom;
          axil_write(1 - hp, byte_addr(w), dd, 4'hf, 0);
          model[w] = dd;
          axil_read(1 - hp, byte_addr(w), 0, gg);
          check_data("free port read", gg, model[w]);
          other_done++;
        end
      end
    join
  endtask

  // ============================================================
  // Test sequence
  // ============================================================
  initial
  begin
    logic [31:0] r;
    int          errs;
    word_addr_t  w;
    axi_addr_t   a;
    data_t       d;
    data_t       d2;
    data_t       got;
    strb_t       s;
    r = $urandom(32'h954a_ea8a);
    arst_n  <= 1'b0;
    gate_en <= 1'b0;
    for (int p = 0; p < 2; p++)
    begin
      awaddr[p]  <= '0;
      awvalid[p] <= 1'b0;
      wdata[p]   <= '0;
      wstrb[p]   <= '0;
      wvalid[p]  <= 1'b0;
      bready[p]  <= 1'b0;
      araddr[p]  <= '0;
      arvalid[p] <= 1'b0;
      rready[p]  <= 1'b0;
      exp_resp[p] = RESP_OKAY;
    end
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;

    errs = err_cnt;
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      d = $urandom;
      axil_write(0, byte_addr(word_addr_t'(i)), d, 4'hf, 0);
      model[i] = d;
    end
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      axil_read(1, byte_addr(word_addr_t'(i)), 0, got);
      check_data("A to B readback", got, model[i]);
    end
    for (int i = 0; i < 32; i++)
    begin
      r = $urandom;
      w = r[7:0];
      d = $urandom;
      axil_write(1, byte_addr(w), d, 4'hf, 0);
      model[w] = d;
      axil_read(0, byte_addr(w), 0, got);
      check_data("B to A readback", got, model[w]);
    end
    end_test("full words across ports", errs);

    errs = err_cnt;
    for (int i = 0; i < 64; i++)
    begin
      r = $urandom;
      w = r[7:0];
      s = r[11:8];
      d = $urandom;
      axil_write(i % 2, byte_addr(w), d, s, 0);
      model[w] = merge(model[w], d, s);
      axil_read((i + 1) % 2, byte_addr(w), 0, got);
      check_data("strobed readback", got, model[w]);
    end
    end_test("byte strobes", errs);

    errs = err_cnt;
    for (int i = 0; i < 8; i++)
    begin
      r = $urandom;
      w = r[7:0];
      d = $urandom;
      fork
        axil_write(0, byte_addr(w), d, 4'hf, 0);
        axil_read(1, byte_addr(w), 0, got);
      join
      model[w] = d;
      check_data("B read against A write", got, model[w]);
    end
    end_test("same word write and read", errs);

    errs = err_cnt;
    for (int i = 0; i < 8; i++)
    begin
      r  = $urandom;
      w  = r[7:0];
      d  = $urandom;
      d2 = $urandom;
      fork
        axil_write(0, byte_addr(w), d, 4'hf, 0);
        axil_write(1, byte_addr(w), d2, 4'hf, 0);
      join
      model[w] = merge(merge(model[w], d, 4'hf), d2, 4'hf);   // B lands one cycle later
      axil_read(0, byte_addr(w), 0, got);
      check_data("double write result", got, model[w]);
    end
    end_test("same word double write", errs);

    errs = err_cnt;
    for (int i = 0; i < 16; i++)
    begin
      r = $urandom;
      a = {(r[11:10] == 2'b00) ? 2'b01 : r[11:10], r[9:0]};
      d = $urandom;
      axil_write(i % 2, a, d, 4'hf, 0);
      axil_read((i + 1) % 2, a, 0, got);
    end
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      axil_read(0, byte_addr(word_addr_t'(i)), 0, got);
      check_data("readback after SLVERR", got, model[i]);
    end
    end_test("out of range addresses", errs);

    errs = err_cnt;
    backpressure_run(0);
    backpressure_run(1);
    end_test("response back-pressure", errs);

    errs = err_cnt;
    @(posedge clk);
    gate_en <= 1'b1;
    backpressure_run(0);
    backpressure_run(1);
    for (int i = 0; i < 32; i++)
    begin
      r = $urandom;
      w = r[7:0];
      s = r[11:8];
      d = $urandom;
      axil_write(i % 2, byte_addr(w), d, s, 0);
      model[w] = merge(model[w], d, s);
    end
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      axil_read(1, byte_addr(word_addr_t'(i)), 0, got);
      check_data("gated clock readback", got, model[i]);
    end
    end_test("gated array clock", errs);

    $display("Summary: %0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0 && !timed_out)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- list.f
+incdir+verification
hw/mem_pkg.sv
hw/clock_gate.sv
hw/mem_2rw_sync_synth.sv
hw/mem_2rw_sync.sv
hw/mem_port_arbiter.sv
hw/axil_mem_port.sv
hw/dual_port_mem_top.sv
verification/dual_port_mem_tb.sv

//--- Makefile
TOP = dual_port_mem_tb

.PHONY: all build run clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f list.f -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee run.log
	@grep -q "^STATUS: PASS$$" run.log && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

clean:
	rm -rf obj_dir run.log
